/* Makefile */
VERILATOR ?= verilator
TOP       ?= cell_search_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and fail on a failing result"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/cell_search_pkg.sv */
package cell_search_pkg;

    // ############################################################
    // sample format
    // ############################################################

    localparam int SAMPLE_W = 8;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } sample_t;

    // ############################################################
    // PSS correlator
    // ############################################################

    localparam int              PSS_LEN  = 16;
    localparam logic [PSS_LEN-1:0] PSS_TAPS = 16'hACE1;  // bit 0 weights the oldest sample
    localparam int              FILL_W   = $clog2(PSS_LEN + 1);
    localparam int              ACC_W    = SAMPLE_W + $clog2(PSS_LEN) + 1;  // holds +-2048
    localparam int              METRIC_W = 14;

    typedef logic [METRIC_W-1:0] metric_t;

    localparam metric_t PEAK_THRESHOLD = metric_t'(1536);

    typedef struct packed {
        sample_t sample;
        metric_t metric;
        logic    peak;
    } corr_out_t;

    // ############################################################
    // burst geometry
    // ############################################################

    localparam int CP_LEN      = 4;
    localparam int SYM_LEN     = 16;
    localparam int SYM_TOTAL   = CP_LEN + SYM_LEN;
    localparam int POS_W       = $clog2(SYM_TOTAL);
    localparam int NUM_SYMBOLS = 4;
    localparam int SYM_IDX_W   = 2;
    localparam int SMP_IDX_W   = 4;

    typedef struct packed {
        logic [SYM_IDX_W-1:0] sym_idx;
        logic [SMP_IDX_W-1:0] smp_idx;
    } sym_tag_t;

endpackage

/* logic/cell_search_top.sv */
`timescale 1ns/1ps

module cell_search_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  cell_search_pkg::sample_t  s_axis_in_tdata_i,
    input  logic                      s_axis_in_tvalid_i,
    output cell_search_pkg::sample_t  m_axis_out_tdata_o,
    output cell_search_pkg::sym_tag_t m_axis_out_tuser_o,
    output logic                      m_axis_out_tlast_o,
    output logic                      m_axis_out_tvalid_o,
    output logic                      pss_detected_o
);

    import cell_search_pkg::*;

    corr_out_t corr;
    logic      corr_valid;
    logic      timer_start;
    logic      timer_step;
    logic      in_body;
    sym_tag_t  sym_tag;
    logic      sym_last;
    logic      burst_done;
    logic      pass;

    pss_correlator i_pss_correlator (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .s_in_tdata_i (s_axis_in_tdata_i),
        .s_in_tvalid_i(s_axis_in_tvalid_i),
        .corr_o       (corr),
        .corr_valid_o (corr_valid)
    );

    frame_sync_fsm i_frame_sync_fsm (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .corr_i        (corr),
        .corr_valid_i  (corr_valid),
        .in_body_i     (in_body),
        .burst_done_i  (burst_done),
        .timer_start_o (timer_start),
        .timer_step_o  (timer_step),
        .pass_o        (pass),
        .pss_detected_o(pss_detected_o)
    );

    symbol_timer i_symbol_timer (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .start_i     (timer_start),
        .step_i      (timer_step),
        .in_body_o   (in_body),
        .sym_tag_o   (sym_tag),
        .sym_last_o  (sym_last),
        .burst_done_o(burst_done)
    );

    symbol_extractor i_symbol_extractor (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .sample_i      (corr.sample),
        .tag_i         (sym_tag),
        .last_i        (sym_last),
        .pass_i        (pass),
        .m_out_tdata_o (m_axis_out_tdata_o),
        .m_out_tuser_o (m_axis_out_tuser_o),
        .m_out_tlast_o (m_axis_out_tlast_o),
        .m_out_tvalid_o(m_axis_out_tvalid_o)
    );

endmodule

/* logic/frame_sync_fsm.sv */
`timescale 1ns/1ps

module frame_sync_fsm (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  cell_search_pkg::corr_out_t corr_i,
    input  logic                       corr_valid_i,
    input  logic                       in_body_i,
    input  logic                       burst_done_i,
    output logic                       timer_start_o,
    output logic                       timer_step_o,
    output logic                       pass_o,
    output logic                       pss_detected_o
);

    import cell_search_pkg::*;

    typedef enum logic {
        ST_SEARCH,
        ST_LOCKED
    } state_t;

    state_t state_q;
    state_t state_d;

    // ############################################################
    // next state and strobes
    // ############################################################

    always_comb begin
        timer_start_o = 1'b0;
        timer_step_o  = 1'b0;
        state_d       = state_q;

        case (state_q)
            ST_SEARCH: begin
                if (corr_valid_i && corr_i.peak) begin
                    timer_start_o = 1'b1;  // the burst starts with the sample after the peak
                    state_d       = ST_LOCKED;
                end
            end
            ST_LOCKED: begin
                timer_step_o = corr_valid_i;  // peaks are ignored while locked
                if (corr_valid_i && burst_done_i) begin
                    state_d = ST_SEARCH;
                end
            end
            default: begin
                state_d = ST_SEARCH;
            end
        endcase
    end

    assign pass_o = timer_step_o && in_body_i;

    // ############################################################
    // state register
    // ############################################################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q        <= ST_SEARCH;
            pss_detected_o <= 1'b0;
        end else begin
            state_q        <= state_d;
            pss_detected_o <= timer_start_o;
        end
    end

    // a detection is only accepted while searching
    start_once_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        state_q == ST_LOCKED |-> !timer_start_o);

    // a burst ends only on a sample the timer was stepping
    burst_end_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        state_q == ST_LOCKED && state_d == ST_SEARCH |-> timer_step_o && pass_o);

endmodule

/* logic/pss_correlator.sv */
`timescale 1ns/1ps

module pss_correlator (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  cell_search_pkg::sample_t   s_in_tdata_i,
    input  logic                       s_in_tvalid_i,
    output cell_search_pkg::corr_out_t corr_o,
    output logic                       corr_valid_o
);

    import cell_search_pkg::*;

    sample_t                   win_q [PSS_LEN];
    logic    [FILL_W-1:0]      fill_q;
    logic                      win_full;
    logic                      vld0_q;

    logic signed [ACC_W-1:0]   sum_re;
    logic signed [ACC_W-1:0]   sum_im;
    logic signed [ACC_W-1:0]   sum_re_q;
    logic signed [ACC_W-1:0]   sum_im_q;
    sample_t                   smp1_q;
    logic                      full1_q;
    logic                      vld1_q;

    metric_t                   abs_re;
    metric_t                   abs_im;
    metric_t                   metric;

    // ############################################################
    // stage 0: sample window
    // ############################################################

    always_ff @(posedge clk_i) begin
        if (s_in_tvalid_i) begin
            for (int k = 0; k < PSS_LEN - 1; k++) begin
                win_q[k] <= win_q[k+1];
            end
            win_q[PSS_LEN-1] <= s_in_tdata_i;  // newest sample sits at the top
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fill_q <= '0;
            vld0_q <= 1'b0;
        end else begin
            vld0_q <= s_in_tvalid_i;
            if (s_in_tvalid_i && !win_full) begin
                fill_q <= fill_q + 1'b1;  // saturates once the window holds PSS_LEN samples
            end
        end
    end

    assign win_full = (fill_q == FILL_W'(PSS_LEN));

    // ############################################################
    // stage 1: signed +-1 sums
    // ############################################################

    always_comb begin
        sum_re = '0;
        sum_im = '0;
        for (int k = 0; k < PSS_LEN; k++) begin
            if (PSS_TAPS[k]) begin
                sum_re = sum_re + $signed(win_q[k].re);
                sum_im = sum_im + $signed(win_q[k].im);
            end else begin
                sum_re = sum_re - $signed(win_q[k].re);
                sum_im = sum_im - $signed(win_q[k].im);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (vld0_q) begin
            sum_re_q <= sum_re;
            sum_im_q <= sum_im;
            smp1_q   <= win_q[PSS_LEN-1];
            full1_q  <= win_full;
        end
    end

    // ############################################################
    // stage 2: magnitude and threshold
    // ############################################################

    always_comb begin
        abs_re = metric_t'(sum_re_q[ACC_W-1] ? -sum_re_q : sum_re_q);
        abs_im = metric_t'(sum_im_q[ACC_W-1] ? -sum_im_q : sum_im_q);
        metric = abs_re + abs_im;  // |re| + |im| stands in for the true magnitude
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            vld1_q       <= 1'b0;
            corr_valid_o <= 1'b0;
        end else begin
            vld1_q       <= vld0_q;
            corr_valid_o <= vld1_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (vld1_q) begin
            corr_o.sample <= smp1_q;
            corr_o.metric <= metric;
            corr_o.peak   <= full1_q && (metric >= PEAK_THRESHOLD);
        end
    end

    // a peak two stages down implies the window had filled by then
    peak_after_fill_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        corr_valid_o && corr_o.peak |-> win_full);

endmodule

/* logic/symbol_extractor.sv */
`timescale 1ns/1ps

module symbol_extractor (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  cell_search_pkg::sample_t  sample_i,
    input  cell_search_pkg::sym_tag_t tag_i,
    input  logic                      last_i,
    input  logic                      pass_i,
    output cell_search_pkg::sample_t  m_out_tdata_o,
    output cell_search_pkg::sym_tag_t m_out_tuser_o,
    output logic                      m_out_tlast_o,
    output logic                      m_out_tvalid_o
);

    import cell_search_pkg::*;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            m_out_tvalid_o <= 1'b0;
            m_out_tlast_o  <= 1'b0;
        end else begin
            m_out_tvalid_o <= pass_i;
            m_out_tlast_o  <= pass_i && last_i;
        end
    end

    // data and tag only move with a passed sample
    always_ff @(posedge clk_i) begin
        if (pass_i) begin
            m_out_tdata_o <= sample_i;
            m_out_tuser_o <= tag_i;
        end
    end

    // tlast must line up with the final body position from the timer
    tlast_pos_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m_out_tlast_o |-> m_out_tvalid_o && m_out_tuser_o.smp_idx == SMP_IDX_W'(SYM_LEN - 1));

endmodule

/* logic/symbol_timer.sv */
`timescale 1ns/1ps

module symbol_timer (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      start_i,
    input  logic                      step_i,
    output logic                      in_body_o,
    output cell_search_pkg::sym_tag_t sym_tag_o,
    output logic                      sym_last_o,
    output logic                      burst_done_o
);

    import cell_search_pkg::*;

    logic [POS_W-1:0]     pos_q;
    logic [SYM_IDX_W-1:0] sym_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pos_q <= '0;
            sym_q <= '0;
        end else if (start_i) begin
            pos_q <= '0;
            sym_q <= '0;
        end else if (step_i) begin
            if (sym_last_o) begin
                pos_q <= '0;
                sym_q <= burst_done_o ? '0 : sym_q + 1'b1;
            end else begin
                pos_q <= pos_q + 1'b1;
            end
        end
    end

    // outputs describe the sample being stepped in this cycle
    always_comb begin
        in_body_o         = (pos_q >= POS_W'(CP_LEN));
        sym_tag_o.sym_idx = sym_q;
        sym_tag_o.smp_idx = SMP_IDX_W'(pos_q - POS_W'(CP_LEN));
        sym_last_o        = (pos_q == POS_W'(SYM_TOTAL - 1));
        burst_done_o      = sym_last_o && (sym_q == SYM_IDX_W'(NUM_SYMBOLS - 1));
    end

    sym_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        sym_q <= SYM_IDX_W'(NUM_SYMBOLS - 1));

endmodule

/* test/cell_search_ref.svh */
`ifndef CELL_SEARCH_REF_SVH
`define CELL_SEARCH_REF_SVH

// ±1 correlation of a window with the PSS taps folded into |re| + |im|
function automatic int window_metric(input sample_t win [PSS_LEN]);
    int acc_re;
    int acc_im;
    acc_re = 0;
    acc_im = 0;
    for (int k = 0; k < PSS_LEN; k++) begin
        acc_re = PSS_TAPS[k] ? acc_re + int'(win[k].re) : acc_re - int'(win[k].re);
        acc_im = PSS_TAPS[k] ? acc_im + int'(win[k].im) : acc_im - int'(win[k].im);
    end
    return (acc_re < 0 ? -acc_re : acc_re) + (acc_im < 0 ? -acc_im : acc_im);
endfunction

// replays the SEARCH/LOCKED frame rule for one accepted sample
task automatic model_step(input sample_t smp, input int acc_cyc);
    sym_tag_t tag;
    for (int k = 0; k < PSS_LEN - 1; k++) begin
        hist[k] = hist[k+1];
    end
    hist[PSS_LEN-1] = smp;
    if (hist_fill < PSS_LEN) hist_fill++;
    if (!ref_locked) begin
        if (hist_fill == PSS_LEN && window_metric(hist) >= int'(PEAK_THRESHOLD)) begin
            ref_locked = 1'b1;
            ref_pos    = 0;
            ref_sym    = 0;
            exp_det_cyc.push_back(acc_cyc + 3);
            model_det_count++;
        end
    end else begin
        if (ref_pos >= CP_LEN) begin
            tag.sym_idx = SYM_IDX_W'(ref_sym);
            tag.smp_idx = SMP_IDX_W'(ref_pos - CP_LEN);
            exp_data.push_back(smp);
            exp_tag.push_back(tag);
            exp_last.push_back(ref_pos == SYM_TOTAL - 1);
            exp_cyc.push_back(acc_cyc + 3);  // the top level has a fixed 3 cycle latency
        end
        if (ref_pos == SYM_TOTAL - 1) begin
            ref_pos = 0;
            if (ref_sym == NUM_SYMBOLS - 1) ref_locked = 1'b0;
            else ref_sym++;
        end else begin
            ref_pos++;
        end
    end
endtask

`endif

/* test/cell_search_tb.sv */
`timescale 1ns/1ps

module cell_search_tb;
    import cell_search_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int FRAME_LEN  = PSS_LEN + 96;
    localparam int TOTAL_SMP  = 200 + 4 * FRAME_LEN;  // noise phase plus up to four frames

    logic clk_i = 1'b0;
    logic rst_n_i = 1'b0;
    sample_t s_axis_in_tdata_i = '0;
    logic s_axis_in_tvalid_i = 1'b0;
    sample_t m_axis_out_tdata_o;
    sym_tag_t m_axis_out_tuser_o;
    logic m_axis_out_tlast_o;
    logic m_axis_out_tvalid_o;
    logic pss_detected_o;

    int seed = 32'h375a8586;
    int cyc = 0;
    sample_t hist [PSS_LEN];
    int hist_fill = 0;
    logic ref_locked = 1'b0;
    int ref_pos = 0;
    int ref_sym = 0;
    int model_det_count = 0;
    int dut_det_count = 0;
    int dut_out_count = 0;
    sample_t exp_data [$];
    sym_tag_t exp_tag [$];
    logic exp_last [$];
    int exp_cyc [$];
    int exp_det_cyc [$];
    sample_t frame_smp [FRAME_LEN];
    int err_data = 0;
    int err_tuser = 0;
    int err_tlast = 0;
    int err_timing = 0;
    int err_other = 0;

    `include "cell_search_ref.svh"

    cell_search_top i_cell_search_top (.*);

    initial forever #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) cyc <= cyc + 1;

    function automatic sample_t rand_sample(input int lim);
        sample_t s;
        s.re = SAMPLE_W'($random(seed) % (lim + 1));  // signed remainder spans -lim..lim
        s.im = SAMPLE_W'($random(seed) % (lim + 1));
        return s;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk_i);
            s_axis_in_tvalid_i = 1'b0;
        end
    endtask

    task automatic send_sample(input sample_t s);
        @(negedge clk_i);
        s_axis_in_tdata_i  = s;
        s_axis_in_tvalid_i = 1'b1;
        model_step(s, cyc + 1);
    endtask

    task automatic send_pss();
        sample_t s;
        for (int k = 0; k < PSS_LEN; k++) begin
            s.re = PSS_TAPS[k] ? 8'sd64 : -8'sd64;
            s.im = s.re;
            send_sample(s);
        end
    endtask

    task automatic send_frame(input logic with_gaps);
        int r;
        for (int i = 0; i < FRAME_LEN; i++) begin
            r = $random(seed);
            if (with_gaps && r[1:0] == 2'd0) idle(int'(r[3:2]) + 1);
            send_sample(frame_smp[i]);
        end
    endtask

    task automatic expect_counts(input int dets, input int outs);
        idle(12);
        if (dut_det_count != dets || dut_out_count != outs) begin
            err_other++;
            $display("detections %0d outputs %0d, wanted %0d and %0d",
                     dut_det_count, dut_out_count, dets, outs);
        end
    endtask

    // ############################################################
    // compare process
    // ############################################################

    always @(negedge clk_i) begin : compare_outputs
        int c;
        if (rst_n_i && pss_detected_o) begin
            dut_det_count++;
            if (exp_det_cyc.size() == 0) begin
                err_other++;
                $display("pss_detected_o pulsed at %0t with no detection expected", $time);
            end else begin
                c = exp_det_cyc.pop_front();
                if (c != cyc) begin
                    err_timing++;
                    $display("Error at %0t: pss_detected_o cycle got %0d expected %0d",
                             $time, cyc, c);
                end
            end
        end
        if (rst_n_i && m_axis_out_tlast_o && !m_axis_out_tvalid_o) begin
            err_tlast++;
            $display("Error at %0t: m_axis_out_tlast_o got 1 expected 0", $time);
        end
        if (rst_n_i && m_axis_out_tvalid_o) begin
            dut_out_count++;
            if (exp_data.size() == 0) begin
                err_other++;
                $display("output sample at %0t with none expected", $time);
            end else begin
                c = exp_cyc.pop_front();
                if (c != cyc) begin
                    err_timing++;
                    $display("Error at %0t: m_axis_out_tvalid_o cycle got %0d expected %0d",
                             $time, cyc, c);
                end
                if (m_axis_out_tdata_o !== exp_data[0]) begin
                    err_data++;
                    $display("Error at %0t: m_axis_out_tdata_o got %h expected %h",
                             $time, m_axis_out_tdata_o, exp_data[0]);
                end
                if (m_axis_out_tuser_o !== exp_tag[0]) begin
                    err_tuser++;
                    $display("Error at %0t: m_axis_out_tuser_o got %h expected %h",
                             $time, m_axis_out_tuser_o, exp_tag[0]);
                end
                if (m_axis_out_tlast_o !== exp_last[0]) begin
                    err_tlast++;
                    $display("Error at %0t: m_axis_out_tlast_o got %b expected %b",
                             $time, m_axis_out_tlast_o, exp_last[0]);
                end
                void'(exp_data.pop_front());
                void'(exp_tag.pop_front());
                void'(exp_last.pop_front());
            end
        end
    end

    // ############################################################
    // stimulus
    // ############################################################

    initial begin
        for (int k = 0; k < PSS_LEN; k++) begin
            frame_smp[k].re = PSS_TAPS[k] ? 8'sd64 : -8'sd64;
            frame_smp[k].im = frame_smp[k].re;
        end
        for (int i = PSS_LEN; i < FRAME_LEN; i++) frame_smp[i] = rand_sample(31);
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        idle(10);  // outputs must stay quiet with no input
        for (int i = 0; i < 200; i++) send_sample(rand_sample(7));
        expect_counts(0, 0);
        send_frame(1'b0);
        expect_counts(1, 64);
        send_frame(1'b1);  // same frame with valid gaps
        expect_counts(2, 128);
        send_pss();
        for (int i = 0; i < 30; i++) send_sample(rand_sample(31));
        send_pss();  // lands inside the burst and is ignored
        for (int i = 0; i < 54; i++) send_sample(rand_sample(31));
        send_pss();
        for (int i = 0; i < 90; i++) send_sample(rand_sample(31));
        expect_counts(4, 256);
        if (exp_data.size() != 0 || exp_det_cyc.size() != 0 ||
            dut_det_count != model_det_count) begin
            err_other++;
            $display("model left %0d samples and %0d detections unmatched",
                     exp_data.size(), exp_det_cyc.size());
        end
        $display("errors: data %0d tuser %0d tlast %0d timing %0d other %0d",
                 err_data, err_tuser, err_tlast, err_timing, err_other);
        if (err_data + err_tuser + err_tlast + err_timing + err_other == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((4 * TOTAL_SMP + 400) * CLK_PERIOD);
        $display("watchdog expired before the stimulus finished");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+test
logic/cell_search_pkg.sv
logic/pss_correlator.sv
logic/symbol_timer.sv
logic/frame_sync_fsm.sv
logic/symbol_extractor.sv
logic/cell_search_top.sv
test/cell_search_tb.sv
